//--- rtl/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// integer data path width
`define RV_XLEN 32

// PC and memory address width in bits
`define RV_PC_W 10

// architectural register count, x0 included
`define RV_NREGS 32

// addi x0, x0, 0
`define RV_NOP 32'h0000_0013

`endif

//--- rtl/rv_pkg.sv
`default_nettype none

package rv_pkg;

    // major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10
    } alu_op_e;

    // writeback source
    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_MEM = 2'd1,
        WB_PC4 = 2'd2
    } wb_sel_e;

    // first ALU operand
    typedef enum logic [1:0] {
        SRC_A_RS1  = 2'd0,
        SRC_A_PC   = 2'd1,
        SRC_A_ZERO = 2'd2
    } src_a_e;

endpackage

`default_nettype wire

//--- rtl/rv_alu.sv
`timescale 1ns/1ns
`default_nettype none
`include "rv_consts.svh"

module rv_alu (
    input  logic [`RV_XLEN-1:0] a,
    input  logic [`RV_XLEN-1:0] b,
    input  rv_pkg::alu_op_e     op,
    output logic [`RV_XLEN-1:0] result,
    output logic                zero
);

    logic [4:0] shamt;

    // shifts only look at the low five bits
    assign shamt = b[4:0];

    always_comb begin
        case (op)
            rv_pkg::ALU_ADD:    result = a + b;
            rv_pkg::ALU_SUB:    result = a - b;
            rv_pkg::ALU_SLL:    result = a << shamt;
            rv_pkg::ALU_SLT:    result = {{(`RV_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            rv_pkg::ALU_SLTU:   result = {{(`RV_XLEN-1){1'b0}}, a < b};
            rv_pkg::ALU_XOR:    result = a ^ b;
            rv_pkg::ALU_SRL:    result = a >> shamt;
            rv_pkg::ALU_SRA:    result = $signed(a) >>> shamt;
            rv_pkg::ALU_OR:     result = a | b;
            rv_pkg::ALU_AND:    result = a & b;
            rv_pkg::ALU_PASS_B: result = b;
            default:            result = '0;
        endcase
    end

    // branch compare uses SUB, so zero means equal
    assign zero = (result == '0);

    // op comes from the ID/EX register and must be one the decoder can produce
    always_comb begin
        if (!$isunknown(op)) begin
            assert (op inside {[rv_pkg::ALU_ADD:rv_pkg::ALU_PASS_B]})
                else $error("rv_alu: illegal op %0h", op);
        end
    end

endmodule

`default_nettype wire

//--- rtl/rv_decoder.sv
`timescale 1ns/1ns
`default_nettype none
`include "rv_consts.svh"

module rv_decoder (
    input  logic [31:0]         instr,
    output logic [`RV_XLEN-1:0] imm,
    output rv_pkg::alu_op_e     alu_op,
    output rv_pkg::src_a_e      src_a,
    output logic                b_is_imm,
    output logic                reg_write,
    output logic                mem_read,
    output logic                mem_write,
    output logic                branch,
    output logic                jump,
    output rv_pkg::wb_sel_e     wb_sel
);

    rv_pkg::opcode_e     opcode;
    logic [2:0]          funct3;
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_s;
    logic [`RV_XLEN-1:0] imm_b;
    logic [`RV_XLEN-1:0] imm_u;
    logic [`RV_XLEN-1:0] imm_j;

    // funct3 plus the alternate bit to an ALU operation
    function automatic rv_pkg::alu_op_e arith_op(input logic [2:0] f3, input logic alt);
        rv_pkg::alu_op_e op;
        case (f3)
            3'b000:  op = alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            3'b001:  op = rv_pkg::ALU_SLL;
            3'b010:  op = rv_pkg::ALU_SLT;
            3'b011:  op = rv_pkg::ALU_SLTU;
            3'b100:  op = rv_pkg::ALU_XOR;
            3'b101:  op = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'b110:  op = rv_pkg::ALU_OR;
            default: op = rv_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode = rv_pkg::opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];

    // sign-extended immediates of each format
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        // defaults give a NOP with every write off
        imm       = '0;
        alu_op    = rv_pkg::ALU_ADD;
        src_a     = rv_pkg::SRC_A_RS1;
        b_is_imm  = 1'b0;
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        branch    = 1'b0;
        jump      = 1'b0;
        wb_sel    = rv_pkg::WB_ALU;
        case (opcode)
            rv_pkg::OP: begin
                alu_op    = arith_op(funct3, instr[30]);
                reg_write = 1'b1;
            end
            rv_pkg::OP_IMM: begin
                // bit 30 is part of the immediate except for SRAI
                imm       = imm_i;
                alu_op    = arith_op(funct3, instr[30] & (funct3 == 3'b101));
                b_is_imm  = 1'b1;
                reg_write = 1'b1;
            end
            rv_pkg::LOAD: begin
                imm       = imm_i;
                b_is_imm  = 1'b1;
                reg_write = 1'b1;
                mem_read  = 1'b1;
                wb_sel    = rv_pkg::WB_MEM;
            end
            rv_pkg::STORE: begin
                imm       = imm_s;
                b_is_imm  = 1'b1;
                mem_write = 1'b1;
            end
            rv_pkg::BRANCH: begin
                imm    = imm_b;
                alu_op = rv_pkg::ALU_SUB;
                branch = 1'b1;
            end
            rv_pkg::LUI: begin
                imm       = imm_u;
                src_a     = rv_pkg::SRC_A_ZERO;
                b_is_imm  = 1'b1;
                reg_write = 1'b1;
            end
            rv_pkg::AUIPC: begin
                imm       = imm_u;
                src_a     = rv_pkg::SRC_A_PC;
                b_is_imm  = 1'b1;
                reg_write = 1'b1;
            end
            rv_pkg::JAL: begin
                imm       = imm_j;
                alu_op    = rv_pkg::ALU_PASS_B;
                b_is_imm  = 1'b1;
                reg_write = 1'b1;
                jump      = 1'b1;
                wb_sel    = rv_pkg::WB_PC4;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/rv_regfile.sv
`timescale 1ns/1ns
`default_nettype none
`include "rv_consts.svh"

module rv_regfile (
    input  logic                CLK,
    input  logic                RESET_N,
    input  logic [4:0]          rs1,
    input  logic [4:0]          rs2,
    input  logic [4:0]          rd,
    input  logic [`RV_XLEN-1:0] wdata,
    input  logic                we,
    output logic [`RV_XLEN-1:0] rdata1,
    output logic [`RV_XLEN-1:0] rdata2
);

    // x0 is cleared at reset and never written
    logic [`RV_XLEN-1:0] regs [0:`RV_NREGS-1];

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    // same-cycle write is visible to decode, except a write to x0
    assign rdata1 = (we && rd != 5'd0 && rd == rs1) ? wdata : regs[rs1];
    assign rdata2 = (we && rd != 5'd0 && rd == rs2) ? wdata : regs[rs2];

    a_x0_zero: assert property (@(posedge CLK) disable iff (!RESET_N)
        ((rs1 == 5'd0) |-> (rdata1 == '0)) and ((rs2 == 5'd0) |-> (rdata2 == '0)))
        else $error("rv_regfile: x0 read back nonzero");

endmodule

`default_nettype wire

//--- rtl/rv_pipeline.sv
`timescale 1ns/1ns
`default_nettype none
`include "rv_consts.svh"

module rv_pipeline (
    input  logic                CLK,
    input  logic                RESET_N,
    output logic [`RV_PC_W-1:0] iaddr,
    input  logic [31:0]         idata,
    output logic [`RV_PC_W-1:0] daddr,
    input  logic [`RV_XLEN-1:0] ddata_r,
    output logic [`RV_XLEN-1:0] ddata_w,
    output logic                mem_write,
    output logic                mem_read
);

    logic [`RV_PC_W-1:0] pc, pc_plus4, br_target;
    logic                redirect;

    logic                ifid_valid;
    logic [31:0]         ifid_instr;
    logic [`RV_PC_W-1:0] ifid_pc, ifid_pc4;

    logic [`RV_XLEN-1:0] dec_imm, rf_rdata1, rf_rdata2;
    rv_pkg::alu_op_e     dec_alu_op;
    rv_pkg::src_a_e      dec_src_a;
    rv_pkg::wb_sel_e     dec_wb_sel;
    logic dec_b_is_imm, dec_reg_write, dec_mem_read, dec_mem_write, dec_branch, dec_jump;

    logic                idex_valid;
    logic [`RV_PC_W-1:0] idex_pc, idex_pc4;
    logic [`RV_XLEN-1:0] idex_rs1_data, idex_rs2_data, idex_imm;
    logic [4:0]          idex_rd;
    rv_pkg::alu_op_e     idex_alu_op;
    rv_pkg::src_a_e      idex_src_a;
    rv_pkg::wb_sel_e     idex_wb_sel;
    logic idex_bne, idex_b_is_imm, idex_reg_write, idex_mem_read, idex_mem_write;
    logic idex_branch, idex_jump;

    logic [`RV_XLEN-1:0] alu_a, alu_b, alu_result;
    logic                alu_zero;

    logic                exmem_valid;
    logic [`RV_XLEN-1:0] exmem_alu, exmem_rs2;
    logic [`RV_PC_W-1:0] exmem_target, exmem_pc4;
    logic [4:0]          exmem_rd;
    rv_pkg::wb_sel_e     exmem_wb_sel;
    logic exmem_zero, exmem_bne, exmem_reg_write, exmem_mem_read, exmem_mem_write;
    logic exmem_branch, exmem_jump;

    logic                memwb_valid, memwb_reg_write;
    logic [`RV_XLEN-1:0] memwb_alu, memwb_mem_data, wb_data;
    logic [`RV_PC_W-1:0] memwb_pc4;
    logic [4:0]          memwb_rd;
    rv_pkg::wb_sel_e     memwb_wb_sel;

    // fetch
    assign pc_plus4 = pc + `RV_PC_W'd4;
    assign iaddr    = {2'b00, pc[`RV_PC_W-1:2]};

    // PC and valid bits; a redirect squashes the three younger slots
    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            pc          <= '0;
            ifid_valid  <= 1'b0;
            idex_valid  <= 1'b0;
            exmem_valid <= 1'b0;
            memwb_valid <= 1'b0;
        end else begin
            pc          <= redirect ? exmem_target : pc_plus4;
            ifid_valid  <= ~redirect;
            idex_valid  <= ifid_valid & ~redirect;
            exmem_valid <= idex_valid & ~redirect;
            memwb_valid <= exmem_valid;
        end
    end

    always_ff @(posedge CLK) begin
        ifid_instr <= redirect ? `RV_NOP : idata;
        ifid_pc    <= pc;
        ifid_pc4   <= pc_plus4;
    end

    // decode
    rv_decoder u_decoder (
        .instr(ifid_instr), .imm(dec_imm), .alu_op(dec_alu_op), .src_a(dec_src_a),
        .b_is_imm(dec_b_is_imm), .reg_write(dec_reg_write), .mem_read(dec_mem_read),
        .mem_write(dec_mem_write), .branch(dec_branch), .jump(dec_jump), .wb_sel(dec_wb_sel)
    );

    rv_regfile u_regfile (
        .CLK(CLK), .RESET_N(RESET_N), .rs1(ifid_instr[19:15]), .rs2(ifid_instr[24:20]),
        .rd(memwb_rd), .wdata(wb_data), .we(memwb_valid & memwb_reg_write),
        .rdata1(rf_rdata1), .rdata2(rf_rdata2)
    );

    always_ff @(posedge CLK) begin
        idex_pc        <= ifid_pc;
        idex_pc4       <= ifid_pc4;
        idex_rs1_data  <= rf_rdata1;
        idex_rs2_data  <= rf_rdata2;
        idex_imm       <= dec_imm;
        idex_rd        <= ifid_instr[11:7];
        // funct3[0] tells BNE from BEQ
        idex_bne       <= ifid_instr[12];
        idex_alu_op    <= dec_alu_op;
        idex_src_a     <= dec_src_a;
        idex_b_is_imm  <= dec_b_is_imm;
        idex_reg_write <= dec_reg_write;
        idex_mem_read  <= dec_mem_read;
        idex_mem_write <= dec_mem_write;
        idex_branch    <= dec_branch;
        idex_jump      <= dec_jump;
        idex_wb_sel    <= dec_wb_sel;
    end

    // execute
    always_comb begin
        case (idex_src_a)
            rv_pkg::SRC_A_RS1: alu_a = idex_rs1_data;
            rv_pkg::SRC_A_PC:  alu_a = {{(`RV_XLEN-`RV_PC_W){1'b0}}, idex_pc};
            default:           alu_a = '0;
        endcase
    end

    assign alu_b     = idex_b_is_imm ? idex_imm : idex_rs2_data;
    assign br_target = idex_pc + idex_imm[`RV_PC_W-1:0];

    rv_alu u_alu (.a(alu_a), .b(alu_b), .op(idex_alu_op), .result(alu_result), .zero(alu_zero));

    always_ff @(posedge CLK) begin
        exmem_alu       <= alu_result;
        exmem_zero      <= alu_zero;
        exmem_rs2       <= idex_rs2_data;
        exmem_target    <= br_target;
        exmem_pc4       <= idex_pc4;
        exmem_rd        <= idex_rd;
        exmem_bne       <= idex_bne;
        exmem_reg_write <= idex_reg_write;
        exmem_mem_read  <= idex_mem_read;
        exmem_mem_write <= idex_mem_write;
        exmem_branch    <= idex_branch;
        exmem_jump      <= idex_jump;
        exmem_wb_sel    <= idex_wb_sel;
    end

    // memory stage, branch taken when zero matches BEQ or differs for BNE
    assign redirect  = exmem_valid & (exmem_jump | (exmem_branch & (exmem_zero ^ exmem_bne)));
    assign daddr     = exmem_alu[`RV_PC_W+1:2];
    assign ddata_w   = exmem_rs2;
    assign mem_write = exmem_valid & exmem_mem_write;
    assign mem_read  = exmem_valid & exmem_mem_read;

    always_ff @(posedge CLK) begin
        memwb_alu       <= exmem_alu;
        memwb_pc4       <= exmem_pc4;
        memwb_rd        <= exmem_rd;
        memwb_reg_write <= exmem_reg_write;
        memwb_wb_sel    <= exmem_wb_sel;
        if (mem_read) begin
            memwb_mem_data <= ddata_r;
        end
    end

    // writeback
    always_comb begin
        case (memwb_wb_sel)
            rv_pkg::WB_MEM: wb_data = memwb_mem_data;
            rv_pkg::WB_PC4: wb_data = {{(`RV_XLEN-`RV_PC_W){1'b0}}, memwb_pc4};
            default:        wb_data = memwb_alu;
        endcase
    end

    a_mem_excl: assert property (@(posedge CLK) disable iff (!RESET_N)
        !(mem_write && mem_read))
        else $error("rv_pipeline: mem_write and mem_read both high");

    // each of the three squashed slots arrives at the memory stage invalid
    a_flush: assert property (@(posedge CLK) disable iff (!RESET_N)
        redirect |=> !exmem_valid ##1 !exmem_valid ##1 !exmem_valid)
        else $error("rv_pipeline: squashed slot reached the memory stage valid");

endmodule

`default_nettype wire

//--- sim/tb_rv_pipeline.sv
`timescale 1ns/1ns
`default_nettype none
`include "rv_consts.svh"

module tb_rv_pipeline;

    // word index of the store that flushed slots use
    localparam int MARKER = 255;

    logic                CLK;
    logic                RESET_N;
    logic [`RV_PC_W-1:0] iaddr;
    logic [31:0]         idata;
    logic [`RV_PC_W-1:0] daddr;
    logic [`RV_XLEN-1:0] ddata_r;
    logic [`RV_XLEN-1:0] ddata_w;
    logic                mem_write;
    logic                mem_read;

    logic [31:0] rom [0:255];
    logic [31:0] ram [0:255];
    logic [31:0] ref_mem [0:255];
    logic [31:0] ref_rf [0:31];
    logic [7:0]  exp_addr [0:255];
    logic [31:0] exp_data [0:255];
    string       test_name [0:7];
    int          test_last [0:7];
    int pc_w, n_exp, store_idx, n_tests, cur_test;
    int errors, errors_mark, passes, fails;
    logic assembled;

    rv_pipeline u_dut (
        .CLK(CLK), .RESET_N(RESET_N), .iaddr(iaddr), .idata(idata), .daddr(daddr),
        .ddata_r(ddata_r), .ddata_w(ddata_w), .mem_write(mem_write), .mem_read(mem_read)
    );

    assign idata   = rom[iaddr[7:0]];
    assign ddata_r = ram[daddr[7:0]];

    always @(posedge CLK) begin
        if (mem_write) begin
            ram[daddr[7:0]] <= ddata_w;
        end
    end

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    // architectural RV32I result, independent of timing
    function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic emit(input logic [31:0] w);
        rom[pc_w] = w;
        pc_w++;
    endtask

    task automatic nops3();
        repeat (3) emit(`RV_NOP);
    endtask

    task automatic set_reg(input logic [4:0] rd, input logic [31:0] v);
        if (rd != 5'd0) begin
            ref_rf[rd] = v;
        end
    endtask

    task automatic op_r(input logic [2:0] f3, input logic alt, input logic [4:0] rd,
                        input logic [4:0] rs1, input logic [4:0] rs2);
        emit({1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011});
        set_reg(rd, alu_model(f3, alt, ref_rf[rs1], ref_rf[rs2]));
        nops3();
    endtask

    task automatic op_i(input logic [2:0] f3, input logic [11:0] imm, input logic [4:0] rd,
                        input logic [4:0] rs1);
        logic alt;
        alt = (f3 == 3'd5) && imm[10];
        emit({imm, rs1, f3, rd, 7'b0010011});
        set_reg(rd, alu_model(f3, alt, ref_rf[rs1], {{20{imm[11]}}, imm}));
        nops3();
    endtask

    task automatic store_word(input logic [4:0] rs2, input int word);
        logic [11:0] imm;
        imm = 12'(word * 4);
        emit({imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011});
        exp_addr[n_exp] = 8'(word);
        exp_data[n_exp] = ref_rf[rs2];
        ref_mem[word] = ref_rf[rs2];
        n_exp++;
    endtask

    // store to the next free result slot
    task automatic store_next(input logic [4:0] rs2, inout int slot);
        store_word(rs2, slot);
        slot++;
    endtask

    task automatic marker_stores();
        repeat (3) emit({7'b0011111, 5'd0, 5'd0, 3'b010, 5'b11100, 7'b0100011});
    endtask

    task automatic load_word(input logic [4:0] rd, input int word);
        emit({12'(word * 4), 5'd0, 3'b010, rd, 7'b0000011});
        set_reg(rd, ref_mem[word]);
        nops3();
    endtask

    task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
        logic [31:0] upper;
        upper = v + 32'h800;
        emit({upper[31:12], rd, 7'b0110111});
        nops3();
        emit({v[11:0], rd, 3'b000, rd, 7'b0010011});
        nops3();
        set_reg(rd, v);
    endtask

    task automatic upper_imm(input logic is_auipc, input logic [19:0] imm, input logic [4:0] rd);
        emit({imm, rd, is_auipc ? 7'b0010111 : 7'b0110111});
        set_reg(rd, {imm, 12'b0} + (is_auipc ? 32'(pc_w * 4 - 4) : 32'd0));
        nops3();
    endtask

    // offset is always 16, so the three slots after a taken branch are skipped
    task automatic branch_fwd(input logic [2:0] f3, input logic [4:0] rs1,
                              input logic [4:0] rs2, inout int slot);
        logic taken;
        taken = (ref_rf[rs1] == ref_rf[rs2]) ^ f3[0];
        emit({1'b0, 6'b0, rs2, rs1, f3, 4'b1000, 1'b0, 7'b1100011});
        if (taken) begin
            marker_stores();
        end else begin
            repeat (3) begin
                store_word(rs1, slot);
                slot++;
            end
        end
    endtask

    task automatic jal_fwd(input logic [4:0] rd);
        set_reg(rd, 32'(pc_w * 4 + 4));
        emit({1'b0, 10'd8, 1'b0, 8'd0, rd, 7'b1101111});
        marker_stores();
    endtask

    task automatic end_test(input string name);
        test_name[n_tests] = name;
        test_last[n_tests] = n_exp - 1;
        n_tests++;
    endtask

    task automatic assemble();
        int slot;
        logic [31:0] a;
        logic [31:0] b;
        slot = 0;
        a = $urandom;
        b = $urandom;
        if (a == b) begin
            b = b ^ 32'd1;
        end
        load_const(5'd1, a);
        load_const(5'd2, b);
        for (int f = 0; f < 8; f++) begin
            op_r(3'(f), 1'b0, 5'd3, 5'd1, 5'd2);
            store_next(5'd3, slot);
            if (f == 0 || f == 5) begin
                op_r(3'(f), 1'b1, 5'd3, 5'd1, 5'd2);
                store_next(5'd3, slot);
            end
        end
        end_test("r-type alu");
        for (int f = 0; f < 8; f++) begin
            if (f == 1 || f == 5) begin
                op_i(3'(f), {7'b0, 5'($urandom)}, 5'd3, 5'd1);
            end else begin
                op_i(3'(f), 12'($urandom), 5'd3, 5'd1);
            end
            store_next(5'd3, slot);
        end
        op_i(3'd5, {7'b0100000, 5'($urandom)}, 5'd3, 5'd1);
        store_next(5'd3, slot);
        end_test("i-type alu");
        upper_imm(1'b0, 20'($urandom), 5'd4);
        store_next(5'd4, slot);
        upper_imm(1'b1, 20'($urandom), 5'd5);
        store_next(5'd5, slot);
        end_test("lui auipc");
        load_const(5'd6, $urandom);
        store_word(5'd6, 200);
        load_word(5'd7, 200);
        store_next(5'd7, slot);
        end_test("sw lw");
        branch_fwd(3'b000, 5'd1, 5'd1, slot);
        branch_fwd(3'b001, 5'd1, 5'd1, slot);
        branch_fwd(3'b001, 5'd1, 5'd2, slot);
        branch_fwd(3'b000, 5'd1, 5'd2, slot);
        jal_fwd(5'd8);
        nops3();
        store_next(5'd8, slot);
        end_test("branch jal");
        op_i(3'd0, 12'h5a5, 5'd0, 5'd0);
        store_next(5'd0, slot);
        end_test("x0 write");
        // park the core on a self loop
        emit({1'b0, 10'd0, 1'b0, 8'd0, 5'd0, 7'b1101111});
    endtask

    a_reset_quiet: assert property (@(posedge CLK)
        !RESET_N |-> (!mem_write && !mem_read && iaddr == '0))
        else begin
            errors = errors + 1;
            $display("memory strobe or fetch address not idle during reset");
        end

    a_store_addr: assert property (@(posedge CLK) disable iff (!RESET_N)
        mem_write |-> daddr[7:0] == exp_addr[store_idx])
        else begin
            errors = errors + 1;
            $display("ERR daddr expected %h got %h",
                     exp_addr[$sampled(store_idx)], $sampled(daddr));
        end

    a_store_data: assert property (@(posedge CLK) disable iff (!RESET_N)
        mem_write |-> ddata_w == exp_data[store_idx])
        else begin
            errors = errors + 1;
            $display("ERR ddata_w expected %h got %h",
                     exp_data[$sampled(store_idx)], $sampled(ddata_w));
        end

    a_no_marker: assert property (@(posedge CLK) disable iff (!RESET_N)
        mem_write |-> daddr[7:0] != 8'(MARKER))
        else begin
            errors = errors + 1;
            $display("a squashed store reached the data memory");
        end

    a_no_extra: assert property (@(posedge CLK) disable iff (!RESET_N)
        mem_write |-> store_idx < n_exp)
        else begin
            errors = errors + 1;
            $display("more stores than the program holds");
        end

    always @(posedge CLK) begin
        if (RESET_N && mem_write) begin
            store_idx <= store_idx + 1;
        end
    end

    // per-test line once its last store has been checked
    always @(negedge CLK) begin
        if (cur_test < n_tests && store_idx > test_last[cur_test]) begin
            if (errors == errors_mark) begin
                passes++;
                $display("test %s: ok", test_name[cur_test]);
            end else begin
                fails++;
                $display("test %s: %0d errors", test_name[cur_test], errors - errors_mark);
            end
            errors_mark = errors;
            cur_test++;
        end
    end

    initial begin
        wait (assembled);
        repeat (16 + 40 * pc_w) @(posedge CLK);
        $display("watchdog: the program did not finish in time");
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        RESET_N = 1'b0;
        assembled = 1'b0;
        void'($urandom(53));
        pc_w = 0;
        n_exp = 0;
        store_idx = 0;
        n_tests = 0;
        cur_test = 0;
        errors = 0;
        errors_mark = 0;
        passes = 0;
        fails = 0;
        for (int i = 0; i < 256; i++) begin
            rom[i] = `RV_NOP;
            ram[i] = 32'hc0de_0000 ^ (i * 32'h0001_0101);
            ref_mem[i] = ram[i];
        end
        for (int i = 0; i < 32; i++) begin
            ref_rf[i] = '0;
        end
        assemble();
        assembled = 1'b1;
        repeat (16) @(posedge CLK);
        #1 RESET_N = 1'b1;
        if (errors == 0) begin
            passes++;
            $display("test reset: ok");
        end else begin
            fails++;
            $display("test reset: %0d errors", errors);
        end
        errors_mark = errors;
        wait (store_idx == n_exp);
        repeat (10) @(posedge CLK);
        @(negedge CLK);
        $display("tests passed %0d failed %0d", passes, fails);
        if (fails == 0 && errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+rtl
rtl/rv_pkg.sv
rtl/rv_alu.sv
rtl/rv_decoder.sv
rtl/rv_regfile.sv
rtl/rv_pipeline.sv
sim/tb_rv_pipeline.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f tb.f --top-module tb_rv_pipeline -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

grep -q "^Result: PASSED$" sim.log
